//--- hw/xif_pkg.sv
/*
 * Types and sizes for the extension-interface traffic between the scalar
 * core and the vector coprocessor: offered instructions, register
 * deliveries, commit and kill events, and returned results.
 * Imported by every module of the coprocessor and by the testbench.
 */
`default_nettype none

package xif_pkg;

	// Instruction id and scalar register widths
	localparam int unsigned IdWidth = 4;
	localparam int unsigned Xlen    = 32;

	typedef logic [IdWidth-1:0] id_t;

	// Instruction offered by the core
	typedef struct packed {
		logic [31:0] instr;
		id_t         id;
		logic [2:0]  frm;
	} issue_req_t;

	// Source registers for an already accepted id
	// rs_valid[0] flags rs1, rs_valid[1] flags rs2
	typedef struct packed {
		id_t             id;
		logic [Xlen-1:0] rs1;
		logic [Xlen-1:0] rs2;
		logic [1:0]      rs_valid;
	} reg_req_t;

	// Commit by id, or kill of that id and all younger ones
	typedef struct packed {
		id_t  id;
		logic kill;
	} commit_t;

	// Result back to the core
	typedef struct packed {
		id_t             id;
		logic [Xlen-1:0] data;
		logic [2:0]      frm;
	} result_t;

endpackage : xif_pkg

`default_nettype wire

//--- hw/vinsn_pkg.sv
/*
 * Instruction-side definitions of the coprocessor: opcode and rounding
 * enums, the custom major opcode, the buffered entry and the ring depth.
 * Used by the decoder, the ring buffer, the ALU and the top level.
 */
`default_nettype none

package vinsn_pkg;

	import xif_pkg::*;

	// Ring buffer size
	localparam int unsigned BufDepth  = 4;
	localparam int unsigned AddrWidth = 2;

	// Major opcode of offloaded instructions (custom-0)
	localparam logic [6:0] OpcCustom = 7'b0001011;

	// Operation, encoded as funct3 of the instruction word
	// funct3 = 3'b111 is left illegal
	typedef enum logic [2:0] {
		op_add = 3'b000,
		op_sub = 3'b001,
		op_and = 3'b010,
		op_or  = 3'b011,
		op_xor = 3'b100,
		op_min = 3'b101,
		op_max = 3'b110
	} vop_e;

	// Rounding mode, carried through to the result
	typedef enum logic [2:0] {
		rm_rne = 3'b000,
		rm_rtz = 3'b001,
		rm_rdn = 3'b010,
		rm_rup = 3'b011,
		rm_rmm = 3'b100
	} roundmode_e;

	// One ring buffer slot
	typedef struct packed {
		id_t             id;
		vop_e            op;
		logic [Xlen-1:0] rs1;
		logic [Xlen-1:0] rs2;
		logic [1:0]      rs_valid;
		roundmode_e      frm;
	} vinsn_t;

endpackage : vinsn_pkg

`default_nettype wire

//--- hw/offload_decoder.sv
/*
 * Combinational offload decoder. Checks the offered instruction word,
 * accepts it when it is legal and the ring buffer has room, and builds
 * the entry that is pushed into the buffer in the same cycle.
 */
`timescale 1ns/100ps
`default_nettype none

module offload_decoder
	import xif_pkg::*;
	import vinsn_pkg::*;
(
	input  logic       issue_valid_i,
	input  issue_req_t issue_req_i,
	input  logic       full_i,
	output logic       issue_accept_o,
	output logic       push_o,
	output vinsn_t     push_entry_o
);

	logic       legal;
	vop_e       op;
	roundmode_e frm;

	// Opcode from funct3, major opcode and funct7 must match
	always_comb begin
		legal = (issue_req_i.instr[6:0] == OpcCustom) && (issue_req_i.instr[31:25] == 7'b0);
		op    = op_add;
		case (issue_req_i.instr[14:12])
			3'b000: op = op_add;
			3'b001: op = op_sub;
			3'b010: op = op_and;
			3'b011: op = op_or;
			3'b100: op = op_xor;
			3'b101: op = op_min;
			3'b110: op = op_max;
			default: legal = 1'b0;
		endcase
	end

	// Rounding field, reserved codes fall back to rne
	always_comb begin
		case (issue_req_i.frm)
			3'b001: frm = rm_rtz;
			3'b010: frm = rm_rdn;
			3'b011: frm = rm_rup;
			3'b100: frm = rm_rmm;
			default: frm = rm_rne;
		endcase
	end

	// Accept needs a legal word and a free slot
	assign issue_accept_o = issue_valid_i && legal && !full_i;
	assign push_o         = issue_accept_o;

	// Registers arrive later
	always_comb begin
		push_entry_o          = '0;
		push_entry_o.id       = issue_req_i.id;
		push_entry_o.op       = op;
		push_entry_o.frm      = frm;
	end

endmodule : offload_decoder

`default_nettype wire

//--- hw/insn_ring_buffer.sv
/*
 * In-order ring buffer between the offload decoder and the ALU.
 * Entries are pushed at the tail, filled with registers by id, marked
 * non-speculative by a commit pointer, rolled back by a kill and popped
 * at the head once filled and committed.
 */
`timescale 1ns/100ps
`default_nettype none

module insn_ring_buffer
	import xif_pkg::*;
	import vinsn_pkg::*;
(
	input  logic     clk_i,
	input  logic     rst_ni,
	// Push from the decoder
	input  logic     push_i,
	input  vinsn_t   push_entry_i,
	// Register delivery by id
	input  logic     reg_valid_i,
	input  reg_req_t reg_req_i,
	// Commit or kill by id
	input  logic     commit_valid_i,
	input  commit_t  commit_i,
	// Status
	output logic     full_o,
	output logic     empty_o,
	// Head pop toward the ALU
	output logic     valid_o,
	input  logic     ready_i,
	output vinsn_t   data_o
);

	// Entry storage and id-to-slot table
	vinsn_t [BufDepth-1:0] mem_d, mem_q;
	logic [2**IdWidth-1:0][AddrWidth-1:0] slot_d, slot_q;
	// Pointers
	logic [AddrWidth-1:0] head_d, head_q;
	logic [AddrWidth-1:0] tail_d, tail_q;
	logic [AddrWidth-1:0] commit_d, commit_q;
	// Commit pointer a full lap ahead of head
	logic lap_d, lap_q;
	logic [AddrWidth:0] usage_d, usage_q;
	// Load enable for the storage
	logic load_en;
	logic do_push, do_pop;
	logic head_committed;
	logic [AddrWidth-1:0] reg_slot, commit_slot;

	assign full_o  = (usage_q == BufDepth[AddrWidth:0]);
	assign empty_o = (usage_q == '0);
	assign do_push = push_i && !full_o;

	// Slot lookups by id
	assign reg_slot    = slot_q[reg_req_i.id];
	assign commit_slot = slot_q[commit_i.id];

	// Next storage contents
	always_comb begin
		mem_d   = mem_q;
		slot_d  = slot_q;
		load_en = 1'b0;
		if (do_push) begin
			load_en                 = 1'b1;
			mem_d[tail_q]           = push_entry_i;
			slot_d[push_entry_i.id] = tail_q;
		end
		// Register fill into the slot of that id
		if (reg_valid_i) begin
			load_en                   = 1'b1;
			mem_d[reg_slot].rs1       = reg_req_i.rs1;
			mem_d[reg_slot].rs2       = reg_req_i.rs2;
			mem_d[reg_slot].rs_valid  = reg_req_i.rs_valid;
		end
	end

	// Head is committed when it lies before the commit pointer
	assign head_committed = (commit_q != head_q) || lap_q;

	// Incoming register write counts in this cycle
	assign valid_o = !empty_o && (mem_d[head_q].rs_valid != '0) && head_committed;
	assign data_o  = mem_d[head_q];
	assign do_pop  = valid_o && ready_i;

	// Pointer and usage update
	always_comb begin
		head_d   = head_q;
		tail_d   = tail_q;
		commit_d = commit_q;
		lap_d    = lap_q;
		usage_d  = usage_q;
		if (do_push) begin
			tail_d  = tail_q + 1'b1;
			usage_d = usage_q + 1'b1;
		end
		if (do_pop) begin
			head_d  = head_q + 1'b1;
			usage_d = usage_d - 1'b1;
			lap_d   = 1'b0;
		end
		// Commit covers that slot and all older ones
		if (commit_valid_i && !commit_i.kill) begin
			commit_d = commit_slot + 1'b1;
			// Whole full buffer committed
			lap_d    = full_o && (commit_d == head_q) && !do_pop;
		end
		// Kill drops that slot and everything younger
		if (commit_valid_i && commit_i.kill && !empty_o) begin
			tail_d  = commit_slot;
			usage_d = {1'b0, commit_slot - head_d};
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			head_q   <= '0;
			tail_q   <= '0;
			commit_q <= '0;
			lap_q    <= 1'b0;
			usage_q  <= '0;
		end else begin
			head_q   <= head_d;
			tail_q   <= tail_d;
			commit_q <= commit_d;
			lap_q    <= lap_d;
			usage_q  <= usage_d;
		end
	end

	// Storage only loads on push or register fill
	always_ff @(posedge clk_i) begin
		if (load_en) begin
			mem_q  <= mem_d;
			slot_q <= slot_d;
		end
	end

endmodule : insn_ring_buffer

`default_nettype wire

//--- hw/operand_alu.sv
/*
 * Operand ALU at the head of the ring buffer. Executes each popped entry
 * on rs1 and rs2 and returns one registered result per pop, tagged with
 * the id and the rounding mode of the entry.
 */
`timescale 1ns/100ps
`default_nettype none

module operand_alu
	import xif_pkg::*;
	import vinsn_pkg::*;
(
	input  logic    clk_i,
	input  logic    rst_ni,
	input  logic    entry_valid_i,
	input  vinsn_t  entry_i,
	output logic    entry_ready_o,
	output logic    result_valid_o,
	output result_t result_o
);

	logic [Xlen-1:0] rs2_eff;
	logic [Xlen-1:0] data;
	logic            rs1_lt;
	result_t         result_d;

	// No back-pressure on the result side
	assign entry_ready_o = 1'b1;

	// rs2 only counts when flagged
	assign rs2_eff = entry_i.rs_valid[1] ? entry_i.rs2 : '0;
	assign rs1_lt  = $signed(entry_i.rs1) < $signed(rs2_eff);

	always_comb begin
		case (entry_i.op)
			op_add: data = entry_i.rs1 + rs2_eff;
			op_sub: data = entry_i.rs1 - rs2_eff;
			op_and: data = entry_i.rs1 & rs2_eff;
			op_or:  data = entry_i.rs1 | rs2_eff;
			op_xor: data = entry_i.rs1 ^ rs2_eff;
			// Signed compare
			op_min: data = rs1_lt ? entry_i.rs1 : rs2_eff;
			op_max: data = rs1_lt ? rs2_eff : entry_i.rs1;
			default: data = '0;
		endcase
	end

	// Tag with id and carried rounding mode
	assign result_d.id   = entry_i.id;
	assign result_d.data = data;
	assign result_d.frm  = entry_i.frm;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			result_valid_o <= 1'b0;
		end else begin
			result_valid_o <= entry_valid_i && entry_ready_o;
		end
	end

	// Single result register, overwritten each cycle
	always_ff @(posedge clk_i) begin
		result_o <= result_d;
	end

endmodule : operand_alu

`default_nettype wire

//--- hw/xif_coproc_top.sv
/*
 * Top level of the offload side of the vector coprocessor.
 * Decoder feeds the in-order ring buffer, which feeds the operand ALU.
 */
`timescale 1ns/100ps
`default_nettype none

module xif_coproc_top
	import xif_pkg::*;
	import vinsn_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_ni,
	// Offered instruction
	input  logic       issue_valid_i,
	input  issue_req_t issue_req_i,
	output logic       issue_accept_o,
	// Register delivery
	input  logic       reg_valid_i,
	input  reg_req_t   reg_req_i,
	// Commit or kill
	input  logic       commit_valid_i,
	input  commit_t    commit_i,
	// Result
	output logic       result_valid_o,
	output result_t    result_o
);

	logic   push;
	vinsn_t push_entry;
	logic   full;
	logic   entry_valid;
	logic   entry_ready;
	vinsn_t head_entry;

	offload_decoder i_decoder (
		.issue_valid_i  (issue_valid_i),
		.issue_req_i    (issue_req_i),
		.full_i         (full),
		.issue_accept_o (issue_accept_o),
		.push_o         (push),
		.push_entry_o   (push_entry)
	);

	insn_ring_buffer i_buffer (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.push_i         (push),
		.push_entry_i   (push_entry),
		.reg_valid_i    (reg_valid_i),
		.reg_req_i      (reg_req_i),
		.commit_valid_i (commit_valid_i),
		.commit_i       (commit_i),
		.full_o         (full),
		.empty_o        (),
		.valid_o        (entry_valid),
		.ready_i        (entry_ready),
		.data_o         (head_entry)
	);

	operand_alu i_alu (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.entry_valid_i  (entry_valid),
		.entry_i        (head_entry),
		.entry_ready_o  (entry_ready),
		.result_valid_o (result_valid_o),
		.result_o       (result_o)
	);

endmodule : xif_coproc_top

`default_nettype wire

//--- test/xif_coproc_chk.sv
/*
 * Protocol checks on the coprocessor top level, attached by bind.
 * Watches accept against the opcode and the buffer status, and the
 * result strobe against the pop at the buffer head.
 */
`timescale 1ns/100ps
`default_nettype none

module xif_coproc_chk
	import xif_pkg::*;
(
	input logic       clk_i,
	input logic       rst_ni,
	input logic       issue_valid_i,
	input issue_req_t issue_req_i,
	input logic       issue_accept_o,
	input logic       full_i,
	input logic       entry_valid_i,
	input logic       result_valid_o
);

	int   err_count = 0;
	logic legal_word;
	logic accepted_q;

	// Custom-0 major opcode, zero funct7, funct3 below 7
	assign legal_word = (issue_req_i.instr[6:0] == 7'b0001011)
		&& (issue_req_i.instr[31:25] == 7'b0) && (issue_req_i.instr[14:12] != 3'b111);

	// Set by the first accept after reset
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			accepted_q <= 1'b0;
		end else if (issue_accept_o) begin
			accepted_q <= 1'b1;
		end
	end

	// Quiet after reset until something was accepted
	a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!accepted_q |-> !result_valid_o)
		else begin err_count++; $error("result before any accepted offer"); end

	// No accept without an offer
	a_accept_offer: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!issue_valid_i |-> !issue_accept_o)
		else begin err_count++; $error("accept without an offer"); end

	a_accept_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
		issue_accept_o |-> legal_word)
		else begin err_count++; $error("illegal opcode accepted"); end

	// Full buffer refuses
	a_accept_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
		full_i |-> !issue_accept_o)
		else begin err_count++; $error("accept while the buffer is full"); end

	// Result only one cycle after a pop
	a_result_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
		result_valid_o |-> $past(entry_valid_i))
		else begin err_count++; $error("result without a pop"); end

endmodule : xif_coproc_chk

`default_nettype wire

//--- test/tb_xif_coproc.sv
/*
 * Testbench for the coprocessor top level. Directed opcode, refusal and
 * kill sequences, then a seeded random mix. A reference queue in
 * acceptance order checks every returned result.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_xif_coproc
	import xif_pkg::*;
	import vinsn_pkg::*;
();

	localparam int NumOps = 280;

	logic       clk_i;
	logic       rst_ni;
	logic       issue_valid;
	issue_req_t issue_req;
	logic       issue_accept;
	logic       reg_valid;
	reg_req_t   reg_req;
	logic       commit_valid;
	commit_t    commit;
	logic       result_valid;
	result_t    result;

	// Reference state, indexed by id
	integer          seed;
	id_t             order_q[$];
	logic [Xlen-1:0] exp_data[16];
	logic [2:0]      exp_op[16];
	logic [2:0]      exp_frm[16];
	bit              filled[16];
	bit              committed[16];
	int              in_flight;
	int              n_committed;
	int              err_count;
	id_t             next_id;

	xif_coproc_top DUT (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.issue_valid_i  (issue_valid),
		.issue_req_i    (issue_req),
		.issue_accept_o (issue_accept),
		.reg_valid_i    (reg_valid),
		.reg_req_i      (reg_req),
		.commit_valid_i (commit_valid),
		.commit_i       (commit),
		.result_valid_o (result_valid),
		.result_o       (result)
	);

	bind xif_coproc_top xif_coproc_chk u_chk (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.issue_valid_i  (issue_valid_i),
		.issue_req_i    (issue_req_i),
		.issue_accept_o (issue_accept_o),
		.full_i         (full),
		.entry_valid_i  (entry_valid),
		.result_valid_o (result_valid_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	// Bounded by the length of the planned work
	initial begin
		repeat (NumOps * 20) @(posedge clk_i);
		$display("Timeout: expected results still missing after %0d cycles", NumOps * 20);
		$display(">>> FAIL");
		$fatal(1);
	end

	task automatic stop_on_error(input string msg);
		err_count++;
		$display("ERR %0t: %s", $time, msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	// ALU rule, rs2 zero unless flagged, min and max signed
	function automatic logic [Xlen-1:0] ref_result(input logic [2:0] f3,
		input logic [Xlen-1:0] a, input logic [Xlen-1:0] b, input logic [1:0] rv);
		logic [Xlen-1:0] y;
		y = rv[1] ? b : '0;
		case (f3)
			3'd0: return a + y;
			3'd1: return a - y;
			3'd2: return a & y;
			3'd3: return a | y;
			3'd4: return a ^ y;
			3'd5: return ($signed(a) < $signed(y)) ? a : y;
			3'd6: return ($signed(a) < $signed(y)) ? y : a;
			default: return '0;
		endcase
	endfunction

	// Result seen at the falling edge, where it is stable
	task automatic check_result();
		id_t id;
		assert (DUT.u_chk.err_count == 0) else stop_on_error("checker assertion failed");
		if (result_valid) begin
			assert (order_q.size() > 0) else stop_on_error("result with nothing in flight");
			id = order_q[0];
			assert (result.id == id)
				else stop_on_error($sformatf("result id %0d, expected %0d", result.id, id));
			assert (filled[id] && committed[id])
				else stop_on_error($sformatf("id %0d returned before fill or commit", id));
			assert (result.data == exp_data[id])
				else stop_on_error($sformatf("id %0d data %h, expected %h",
					id, result.data, exp_data[id]));
			assert (result.frm == exp_frm[id])
				else stop_on_error($sformatf("id %0d frm %0d, expected %0d",
					id, result.frm, exp_frm[id]));
			void'(order_q.pop_front());
			in_flight--;
			n_committed--;
		end
	endtask

	// One cycle, strobes dropped
	task automatic tick();
		@(negedge clk_i);
		issue_valid  = 1'b0;
		reg_valid    = 1'b0;
		commit_valid = 1'b0;
		check_result();
	endtask

	task automatic offer(input logic [2:0] f3, input logic [6:0] f7, input logic [2:0] frm);
		logic legal;
		tick();
		legal                 = (f7 == 7'b0) && (f3 != 3'b111);
		issue_valid           = 1'b1;
		issue_req.instr       = {f7, 10'b0, f3, 5'b0, 7'b0001011};
		issue_req.id          = next_id;
		issue_req.frm         = frm;
		#1;
		if (legal && in_flight < int'(BufDepth)) begin
			assert (issue_accept) else stop_on_error("legal offer with room refused");
			order_q.push_back(next_id);
			exp_op[next_id]    = f3;
			// Reserved rounding codes read as rne
			exp_frm[next_id]   = (frm > 3'd4) ? 3'd0 : frm;
			filled[next_id]    = 1'b0;
			committed[next_id] = 1'b0;
			in_flight++;
			next_id++;
		end else begin
			assert (!issue_accept) else stop_on_error("illegal or overflowing offer accepted");
		end
	endtask

	task automatic deliver(input int k);
		id_t             id;
		logic [Xlen-1:0] rs1;
		logic [Xlen-1:0] rs2;
		logic [1:0]      rv;
		id  = order_q[k];
		rs1 = $random(seed);
		rs2 = $random(seed);
		rv  = 2'd1 + 2'($unsigned($random(seed)) % 3);
		tick();
		reg_valid         = 1'b1;
		reg_req.id        = id;
		reg_req.rs1       = rs1;
		reg_req.rs2       = rs2;
		reg_req.rs_valid  = rv;
		exp_data[id]      = ref_result(exp_op[id], rs1, rs2, rv);
		filled[id]        = 1'b1;
	endtask

	// Commits go in acceptance order
	task automatic commit_next();
		tick();
		commit_valid  = 1'b1;
		commit.id     = order_q[n_committed];
		commit.kill   = 1'b0;
		committed[order_q[n_committed]] = 1'b1;
		n_committed++;
	endtask

	// Drops entry k and all younger ones
	task automatic kill_from(input int k);
		id_t id;
		id_t last;
		id = order_q[k];
		tick();
		commit_valid = 1'b1;
		commit.id    = id;
		commit.kill  = 1'b1;
		// Target is uncommitted, so it is still queued after the tick
		do begin
			last = order_q.pop_back();
			in_flight--;
		end while (last != id);
	endtask

	// Random unfilled entry, or -1
	function automatic int pick_unfilled();
		int cand[$];
		for (int i = 0; i < order_q.size(); i++)
			if (!filled[order_q[i]]) cand.push_back(i);
		if (cand.size() == 0) return -1;
		return cand[$unsigned($random(seed)) % cand.size()];
	endfunction

	task automatic drain();
		int k;
		k = pick_unfilled();
		while (k >= 0) begin
			deliver(k);
			k = pick_unfilled();
		end
		while (n_committed < order_q.size()) commit_next();
		while (order_q.size() > 0) tick();
	endtask

	initial begin
		int r;
		int n;
		seed         = 40;
		rst_ni       = 1'b0;
		issue_valid  = 1'b0;
		issue_req    = '0;
		reg_valid    = 1'b0;
		reg_req      = '0;
		commit_valid = 1'b0;
		commit       = '0;
		in_flight    = 0;
		n_committed  = 0;
		err_count    = 0;
		next_id      = '0;
		repeat (8) @(negedge clk_i);
		rst_ni = 1'b1;

		// Idle after reset
		repeat (4) tick();

		// Each opcode alone
		for (int f = 0; f < 7; f++) begin
			offer(3'(f), 7'b0, 3'(f));
			deliver(0);
			commit_next();
			drain();
		end

		// Registers in reverse order
		repeat (3) offer(3'd0, 7'b0, 3'd1);
		deliver(2);
		deliver(1);
		deliver(0);
		repeat (3) commit_next();
		drain();

		// Full buffer, then refusals
		repeat (4) offer(3'($unsigned($random(seed)) % 7), 7'b0, 3'd2);
		offer(3'd0, 7'b0, 3'd0);
		offer(3'd7, 7'b0, 3'd0);
		offer(3'd0, 7'h01, 3'd0);

		// Kill the second and all younger
		commit_next();
		kill_from(1);
		drain();
		repeat (2) offer(3'd6, 7'b0, 3'd3);
		drain();

		// Seeded random mix
		for (int i = 0; i < 200; i++) begin
			r = $unsigned($random(seed)) % 16;
			n = order_q.size() - n_committed;
			if (r < 6) begin
				offer(3'($random(seed)), 7'b0, 3'($random(seed)));
			end else if (r < 10 && pick_unfilled() >= 0) begin
				deliver(pick_unfilled());
			end else if (r >= 10 && r < 14 && n > 0) begin
				commit_next();
			end else if (r == 14 && n > 0) begin
				kill_from(n_committed + ($unsigned($random(seed)) % n));
			end else begin
				tick();
			end
		end
		drain();
		repeat (3) tick();

		if (err_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule : tb_xif_coproc

`default_nettype wire

//--- compile.f
hw/xif_pkg.sv
hw/vinsn_pkg.sv
hw/offload_decoder.sv
hw/insn_ring_buffer.sv
hw/operand_alu.sv
hw/xif_coproc_top.sv
test/xif_coproc_chk.sv
test/tb_xif_coproc.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the coprocessor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_xif_coproc \
	-Mdir obj_dir -o sim

out=$(./obj_dir/sim 2>&1) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -qF ">>> PASS"
